/* include/fb_cfg.svh */
`ifndef FB_CFG_SVH
`define FB_CFG_SVH

// active area, kept small for fast simulation
`define FB_H_DISP        16
`define FB_V_DISP        8

// horizontal blanking in pixel clocks
`define FB_H_FRONT       2
`define FB_H_SYNC        2
`define FB_H_BACK        2

// vertical blanking in lines
`define FB_V_FRONT       1
`define FB_V_SYNC        1
`define FB_V_BACK        2

`define FB_WR_DIV        4       // cycles between run samples
`define FB_WR_FIFO_DEPTH 8
`define FB_RD_FIFO_DEPTH 8
`define FB_ADDR_W        7       // covers H_DISP * V_DISP words

`endif

/* rtl/fb_pkg.sv */
`include "fb_cfg.svh"

package fb_pkg;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

    typedef logic [`FB_ADDR_W-1:0] fb_addr_t;   // linear frame address

    // one pixel write bound for the frame store
    typedef struct packed {
        fb_addr_t addr;
        rgb_t     pix;
    } wr_req_t;

    typedef struct packed {
        logic hsync;                            // active high
        logic vsync;                            // active high
        logic de;
        rgb_t rgb;                              // zero outside de
    } video_t;

endpackage

/* rtl/stream_fifo.sv */
`timescale 1ns/10ps

module stream_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 8
)
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       push,
    input  payload_t                   din,
    input  logic                       pop,
    output payload_t                   dout,
    output logic                       full,
    output logic                       empty,
    output logic [$clog2(DEPTH+1)-1:0] count
);
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             do_push;
    logic             do_pop;

    assign full    = (count == CNT_W'(DEPTH));
    assign empty   = (count == '0);
    assign do_push = push && !full;    // overflow is dropped
    assign do_pop  = pop && !empty;
    assign dout    = mem[rd_ptr];      // show-ahead head entry

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;       // idle or push and pop together
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (do_push)
            mem[wr_ptr] <= din;
    end

endmodule

/* rtl/pixel_run_writer.sv */
`timescale 1ns/10ps
`include "fb_cfg.svh"

module pixel_run_writer
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            ready,
    input  logic            enable,
    input  logic [15:0]     x_pos,
    input  logic [15:0]     y_pos,
    input  logic [15:0]     len,
    input  fb_pkg::rgb_t    pixel,
    output logic            busy,
    input  logic            wr_full,
    output logic            wr_push,
    output fb_pkg::wr_req_t wr_req
);
    import fb_pkg::*;

    localparam int DIV_W     = $clog2(`FB_WR_DIV);
    localparam int LAST_ADDR = `FB_H_DISP * `FB_V_DISP - 1;

    logic             done;        // run finished, cleared by enable low
    logic             pend;        // sampled request waiting for fifo room
    logic [DIV_W-1:0] div_cnt;
    logic [15:0]      remain;      // pixels left to push
    fb_addr_t         addr;        // address of the next sample
    logic [31:0]      start_addr;
    logic             start;
    logic             tick;

    assign start_addr = {16'd0, x_pos} + {16'd0, y_pos} * `FB_H_DISP;
    assign start      = ready && enable && !busy && !done;
    assign tick       = busy && !pend && (remain != '0)
                        && (div_cnt == DIV_W'(`FB_WR_DIV - 1));
    assign wr_push    = pend && !wr_full;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            busy    <= 1'b0;
            done    <= 1'b0;
            pend    <= 1'b0;
            div_cnt <= '0;
            remain  <= '0;
            addr    <= '0;
        end
        else if (start)
        begin
            busy    <= 1'b1;
            remain  <= len;
            addr    <= fb_addr_t'(start_addr[`FB_ADDR_W-1:0]);
            div_cnt <= '0;
        end
        else if (busy)
        begin
            if (div_cnt != DIV_W'(`FB_WR_DIV - 1))
                div_cnt <= div_cnt + 1'b1;
            else if (tick)
                div_cnt <= '0;             // otherwise hold at the sample point
            if (tick)
            begin
                pend <= 1'b1;
                addr <= (addr == fb_addr_t'(LAST_ADDR)) ? '0 : addr + 1'b1;
            end
            if (wr_push)
            begin
                pend   <= 1'b0;
                remain <= remain - 1'b1;
            end
            if (remain == '0 || (wr_push && remain == 16'd1))
            begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
        else if (!enable)
            done <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (tick)
            wr_req <= {addr, pixel};       // held until pushed
    end

endmodule

/* rtl/frame_store.sv */
`timescale 1ns/10ps
`include "fb_cfg.svh"

module frame_store
(
    input  logic             clk,
    input  logic             rst_n,
    output logic             ready,
    input  logic             wr_empty,
    input  fb_pkg::wr_req_t  wr_req,
    output logic             wr_pop,
    input  logic             rd,
    input  fb_pkg::fb_addr_t raddr,
    output fb_pkg::rgb_t     rdata,
    output logic             rvalid
);
    import fb_pkg::*;

    localparam int WORDS = `FB_H_DISP * `FB_V_DISP;

    rgb_t     mem [WORDS];
    fb_addr_t clr_addr;    // clear sweep position
    logic     rd_go;

    // single port, the scanout read owns the cycle
    assign rd_go  = ready && rd;
    assign wr_pop = ready && !wr_empty && !rd;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ready    <= 1'b0;
            clr_addr <= '0;
            rvalid   <= 1'b0;
        end
        else
        begin
            rvalid <= rd_go;
            if (!ready)
            begin
                clr_addr <= clr_addr + 1'b1;
                ready    <= (clr_addr == fb_addr_t'(WORDS - 1));
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!ready)
            mem[clr_addr] <= '0;          // black
        else if (wr_pop)
            mem[wr_req.addr] <= wr_req.pix;
        if (rd_go)
            rdata <= mem[raddr];
    end

endmodule

/* rtl/scan_prefetch.sv */
`timescale 1ns/10ps
`include "fb_cfg.svh"

module scan_prefetch
(
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     ready,
    input  logic [$clog2(`FB_RD_FIFO_DEPTH+1)-1:0]   fifo_count,
    output logic                                     rd,
    output fb_pkg::fb_addr_t                         raddr,
    input  logic                                     rvalid,
    input  fb_pkg::rgb_t                             rdata,
    output logic                                     push,
    output fb_pkg::rgb_t                             pixel
);
    import fb_pkg::*;

    localparam int CNT_W     = $clog2(`FB_RD_FIFO_DEPTH + 1);
    localparam int LAST_ADDR = `FB_H_DISP * `FB_V_DISP - 1;

    logic [CNT_W-1:0] in_flight;   // reads issued, data not yet back
    logic [CNT_W:0]   booked;      // fifo slots already spoken for

    assign booked = {1'b0, fifo_count} + {1'b0, in_flight};
    assign rd     = ready && (booked < (CNT_W + 1)'(`FB_RD_FIFO_DEPTH));
    assign push   = rvalid;
    assign pixel  = rdata;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            raddr     <= '0;
            in_flight <= '0;
        end
        else
        begin
            if (rd)
                raddr <= (raddr == fb_addr_t'(LAST_ADDR)) ? '0 : raddr + 1'b1;
            case ({rd, rvalid})
                2'b10:   in_flight <= in_flight + 1'b1;
                2'b01:   in_flight <= in_flight - 1'b1;
                default: in_flight <= in_flight;
            endcase
        end
    end

endmodule

/* rtl/raster_timing.sv */
`timescale 1ns/10ps
`include "fb_cfg.svh"

module raster_timing
(
    input  logic           clk,
    input  logic           rst_n,
    input  logic           ready,
    input  logic           pix_empty,
    input  fb_pkg::rgb_t   pix,
    output logic           pop,
    output fb_pkg::video_t video
);
    // each axis runs back porch, active, front porch, sync
    localparam int H_ACT_BEG  = `FB_H_BACK;
    localparam int H_ACT_END  = H_ACT_BEG + `FB_H_DISP;
    localparam int H_SYNC_BEG = H_ACT_END + `FB_H_FRONT;
    localparam int H_TOTAL    = H_SYNC_BEG + `FB_H_SYNC;
    localparam int V_ACT_BEG  = `FB_V_BACK;
    localparam int V_ACT_END  = V_ACT_BEG + `FB_V_DISP;
    localparam int V_SYNC_BEG = V_ACT_END + `FB_V_FRONT;
    localparam int V_TOTAL    = V_SYNC_BEG + `FB_V_SYNC;
    localparam int H_W        = $clog2(H_TOTAL);
    localparam int V_W        = $clog2(V_TOTAL);

    logic [H_W-1:0] h_cnt;
    logic [V_W-1:0] v_cnt;
    logic           h_act;
    logic           v_act;
    logic           active;
    logic           line_end;

    assign h_act    = (h_cnt >= H_W'(H_ACT_BEG)) && (h_cnt < H_W'(H_ACT_END));
    assign v_act    = (v_cnt >= V_W'(V_ACT_BEG)) && (v_cnt < V_W'(V_ACT_END));
    assign active   = ready && h_act && v_act;
    assign line_end = (h_cnt == H_W'(H_TOTAL - 1));
    assign pop      = active && !pix_empty;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            h_cnt <= '0;
            v_cnt <= '0;
        end
        else if (ready)                   // frame starts once the store is cleared
        begin
            h_cnt <= line_end ? '0 : h_cnt + 1'b1;
            if (line_end)
                v_cnt <= (v_cnt == V_W'(V_TOTAL - 1)) ? '0 : v_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            video <= '0;
        else
        begin
            video.hsync <= ready && (h_cnt >= H_W'(H_SYNC_BEG));
            video.vsync <= ready && (v_cnt >= V_W'(V_SYNC_BEG));
            video.de    <= active;
            video.rgb   <= pop ? pix : '0;    // black outside de
        end
    end

endmodule

/* rtl/fb_display_top.sv */
`timescale 1ns/10ps
`include "fb_cfg.svh"

module fb_display_top
(
    input  logic           clk,
    input  logic           rst_n,
    input  logic           enable,
    input  logic [15:0]    x_pos,
    input  logic [15:0]    y_pos,
    input  logic [15:0]    len,
    input  fb_pkg::rgb_t   pixel,
    output logic           busy,
    output logic           ready,
    output fb_pkg::video_t video
);
    import fb_pkg::*;

    wr_req_t  wr_req;       // writer to write fifo
    wr_req_t  wr_head;      // write fifo to store
    logic     wr_push;
    logic     wr_pop;
    logic     wr_full;
    logic     wr_empty;
    logic     rd;
    fb_addr_t raddr;
    rgb_t     rdata;
    logic     rvalid;
    rgb_t     pix_in;
    rgb_t     pix_out;
    logic     pix_push;
    logic     pix_pop;
    logic     pix_empty;
    logic [$clog2(`FB_RD_FIFO_DEPTH+1)-1:0] pix_count;

    pixel_run_writer pixel_run_writer_i (
        .clk(clk), .rst_n(rst_n), .ready(ready), .enable(enable),
        .x_pos(x_pos), .y_pos(y_pos), .len(len), .pixel(pixel), .busy(busy),
        .wr_full(wr_full), .wr_push(wr_push), .wr_req(wr_req)
    );

    stream_fifo #(.payload_t(wr_req_t), .DEPTH(`FB_WR_FIFO_DEPTH)) wr_fifo_i (
        .clk(clk), .rst_n(rst_n), .push(wr_push), .din(wr_req), .pop(wr_pop),
        .dout(wr_head), .full(wr_full), .empty(wr_empty), .count()
    );

    frame_store frame_store_i (
        .clk(clk), .rst_n(rst_n), .ready(ready), .wr_empty(wr_empty),
        .wr_req(wr_head), .wr_pop(wr_pop), .rd(rd), .raddr(raddr),
        .rdata(rdata), .rvalid(rvalid)
    );

    scan_prefetch scan_prefetch_i (
        .clk(clk), .rst_n(rst_n), .ready(ready), .fifo_count(pix_count),
        .rd(rd), .raddr(raddr), .rvalid(rvalid), .rdata(rdata),
        .push(pix_push), .pixel(pix_in)
    );

    stream_fifo #(.payload_t(rgb_t), .DEPTH(`FB_RD_FIFO_DEPTH)) pix_fifo_i (
        .clk(clk), .rst_n(rst_n), .push(pix_push), .din(pix_in), .pop(pix_pop),
        .dout(pix_out), .full(), .empty(pix_empty), .count(pix_count)
    );

    raster_timing raster_timing_i (
        .clk(clk), .rst_n(rst_n), .ready(ready), .pix_empty(pix_empty),
        .pix(pix_out), .pop(pix_pop), .video(video)
    );

endmodule

/* verification/fb_display_checker.sv */
`timescale 1ns/10ps
`include "fb_cfg.svh"

module fb_display_checker
(
    input logic                                     clk,
    input logic                                     rst_n,
    input logic                                     busy,
    input logic                                     ready,
    input logic                                     pix_push,
    input logic                                     pix_pop,
    input logic [$clog2(`FB_RD_FIFO_DEPTH+1)-1:0]   pix_count,
    input fb_pkg::video_t                           video
);
    localparam int CNT_W = $clog2(`FB_RD_FIFO_DEPTH + 1);

    pix_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        pix_push |-> (pix_count != CNT_W'(`FB_RD_FIFO_DEPTH)))
        else $error("pixel fifo pushed while full");

    // every de cycle carries a pixel popped one cycle earlier
    de_has_pixel: assert property (@(posedge clk) disable iff (!rst_n)
        video.de |-> $past(pix_pop))
        else $error("raster reached the active area with an empty pixel fifo");

    busy_needs_ready: assert property (@(posedge clk) disable iff (!rst_n)
        !ready |-> !busy)
        else $error("writer busy before the frame store is ready");

endmodule

/* verification/fb_display_tb.sv */
`timescale 1ns/10ps
`include "fb_cfg.svh"

module fb_display_tb;
    import fb_pkg::*;

    localparam int WORDS     = `FB_H_DISP * `FB_V_DISP;
    localparam int H_TOTAL   = `FB_H_BACK + `FB_H_DISP + `FB_H_FRONT + `FB_H_SYNC;
    localparam int V_TOTAL   = `FB_V_BACK + `FB_V_DISP + `FB_V_FRONT + `FB_V_SYNC;
    localparam int FRAME_CYC = H_TOTAL * V_TOTAL;
    localparam int RUN_CNT   = 7;

    typedef struct packed {
        logic [15:0] x;
        logic [15:0] y;
        logic [15:0] len;
        rgb_t        pix;
        logic        hold;        // enable stays high after the run
    } run_t;

    logic        clk;
    logic        rst_n;
    logic        enable;
    logic [15:0] x_pos;
    logic [15:0] y_pos;
    logic [15:0] len;
    rgb_t        pixel;
    logic        busy;
    logic        ready;
    video_t      video;

    rgb_t        model [WORDS];   // expected frame contents
    rgb_t        frame [WORDS];   // last captured frame
    run_t        runs  [RUN_CNT];

    fb_display_top fb_display_top_i (
        .clk(clk), .rst_n(rst_n), .enable(enable), .x_pos(x_pos), .y_pos(y_pos),
        .len(len), .pixel(pixel), .busy(busy), .ready(ready), .video(video)
    );

    bind fb_display_top fb_display_checker fb_display_checker_i (
        .clk(clk), .rst_n(rst_n), .busy(busy), .ready(ready),
        .pix_push(pix_push), .pix_pop(pix_pop), .pix_count(pix_count), .video(video)
    );

    always #20 clk = ~clk;

    task automatic abort_run();
        $display("** FAIL **");
        $fatal(1, "simulation stopped after an error");
    endtask

    task automatic flag_mismatch(input string msg);
        $display("FAIL at %0t ns: %s", $time, msg);
        abort_run();
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timed out at %0t ns while waiting for %s", $time, what);
        abort_run();
    endtask

    // columns are x, y, len, rgb, hold
    task automatic fill_run_table();
        runs[0] = {16'd0,  16'd0, 16'd5,  24'hff0000, 1'b0};   // top left corner
        runs[1] = {16'd3,  16'd2, 16'd4,  24'h00ff00, 1'b1};
        runs[2] = {16'd10, 16'd5, 16'd3,  24'h0000ff, 1'b0};
        runs[3] = {16'd12, 16'd7, 16'd10, 24'h123456, 1'b0};   // wraps past the last address
        runs[4] = {16'd5,  16'd6, 16'd0,  24'habcdef, 1'b1};   // zero length
        runs[5] = {16'd2,  16'd3, 16'd40, 24'hc0ffee, 1'b0};   // longer than the write fifo
        runs[6] = {16'd15, 16'd1, 16'd1,  24'h7f7f7f, 1'b1};
    endtask

    function automatic void paint_model(input run_t e);
        int a;
        int i;
        a = (int'(e.x) + int'(e.y) * `FB_H_DISP) % WORDS;
        for (i = 0; i < int'(e.len); i++)
        begin
            model[a] = e.pix;
            a = (a + 1) % WORDS;          // back to address 0 after the frame end
        end
    endfunction

    task automatic apply_run(input run_t e);
        int n;
        int limit;
        limit = (int'(e.len) + 4) * `FB_WR_DIV + 2 * FRAME_CYC;
        @(posedge clk);
        x_pos  <= e.x;
        y_pos  <= e.y;
        len    <= e.len;
        pixel  <= e.pix;
        enable <= 1'b1;
        n = 0;
        do
        begin
            @(negedge clk);
            n++;
        end
        while (!busy && n < 8);
        if (!busy)
            stop_on_timeout("busy to rise at the run start");
        assert (n == 2)
            else flag_mismatch($sformatf("busy rose %0d cycles after enable, expected 1",
                n - 1));
        n = 0;
        do
        begin
            @(negedge clk);
            n++;
        end
        while (busy && n < limit);
        if (busy)
            stop_on_timeout("busy to fall at the run end");
        assert (n >= int'(e.len) * `FB_WR_DIV)
            else flag_mismatch($sformatf("run of %0d pixels took only %0d cycles", e.len, n));
        if (e.len == 16'd0)
            assert (n == 1)
                else flag_mismatch($sformatf("zero length run kept busy %0d cycles", n));
        paint_model(e);
        if (e.hold)
        begin
            repeat (4 * `FB_WR_DIV)
            begin
                @(negedge clk);
                assert (!busy)
                    else flag_mismatch("busy rose again while enable stayed high");
            end
        end
        @(posedge clk);
        enable <= 1'b0;                   // clears the run-done latch
        repeat (2) @(posedge clk);
    endtask

    task automatic count_vsync_rises(input int frames);
        int   seen;
        int   n;
        logic prev;
        seen = 0;
        n    = 0;
        @(negedge clk);
        prev = video.vsync;
        while (seen < frames && n < (frames + 1) * FRAME_CYC)
        begin
            @(negedge clk);
            n++;
            if (video.vsync && !prev)
                seen++;
            prev = video.vsync;
        end
        if (seen < frames)
            stop_on_timeout("vsync rising edges");
    endtask

    // starts right after a vsync rise and runs to the next one
    task automatic capture_frame();
        int   n;
        int   pix_cnt;
        int   line_de;
        int   lines;
        int   hs_rises;
        logic prev_de;
        logic prev_vs;
        logic prev_hs;
        logic frame_end;
        n         = 0;
        pix_cnt   = 0;
        line_de   = 0;
        lines     = 0;
        hs_rises  = 0;
        prev_de   = 1'b0;
        prev_vs   = 1'b1;
        prev_hs   = 1'b0;
        frame_end = 1'b0;
        while (!frame_end && n < 2 * FRAME_CYC)
        begin
            @(negedge clk);
            n++;
            if (video.de)
            begin
                if (pix_cnt < WORDS)
                    frame[pix_cnt] = video.rgb;
                pix_cnt++;
                line_de++;
            end
            else
            begin
                assert (video.rgb == '0)
                    else flag_mismatch($sformatf("rgb %06h outside de", video.rgb));
                if (prev_de)
                begin
                    assert (line_de == `FB_H_DISP)
                        else flag_mismatch($sformatf("line %0d has %0d de cycles", lines, line_de));
                    lines++;
                    line_de = 0;
                end
            end
            if (video.hsync && !prev_hs)
                hs_rises++;
            frame_end = video.vsync && !prev_vs;
            prev_de   = video.de;
            prev_vs   = video.vsync;
            prev_hs   = video.hsync;
        end
        if (!frame_end)
            stop_on_timeout("the end of the captured frame");
        assert (lines == `FB_V_DISP)
            else flag_mismatch($sformatf("frame has %0d active lines", lines));
        assert (pix_cnt == WORDS)
            else flag_mismatch($sformatf("frame has %0d de pixels", pix_cnt));
        assert (hs_rises == V_TOTAL)
            else flag_mismatch($sformatf("frame has %0d hsync pulses, expected %0d",
                hs_rises, V_TOTAL));
    endtask

    task automatic compare_frame(input int frames);
        int a;
        count_vsync_rises(frames);
        capture_frame();
        for (a = 0; a < WORDS; a++)
            assert (frame[a] == model[a])
                else flag_mismatch($sformatf("pixel x %0d y %0d is %06h, expected %06h",
                    a % `FB_H_DISP, a / `FB_H_DISP, frame[a], model[a]));
    endtask

    initial
    begin
        int cyc;
        int r;
        clk    = 1'b0;
        rst_n  = 1'b0;
        enable = 1'b0;
        x_pos  = '0;
        y_pos  = '0;
        len    = '0;
        pixel  = '0;
        fill_run_table();
        foreach (model[a])
            model[a] = '0;
        @(posedge clk);
        @(negedge clk);
        assert (!busy && !ready && !video.hsync && !video.vsync && !video.de)
            else flag_mismatch("outputs not low during reset");
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);                   // first clock edge out of reset comes next
        cyc = 0;
        do
        begin
            @(negedge clk);
            cyc++;
            assert (ready || (!video.hsync && !video.vsync && !video.de))
                else flag_mismatch("video active before ready");
        end
        while (!ready && cyc < 4 * WORDS);
        if (!ready)
            stop_on_timeout("ready after reset");
        assert (cyc == WORDS)
            else flag_mismatch($sformatf("ready rose after %0d cycles, expected %0d", cyc, WORDS));
        compare_frame(1);                 // store cleared to black
        for (r = 0; r < RUN_CNT; r++)
            apply_run(runs[r]);
        compare_frame(2);
        $display("** PASS **");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+include
rtl/fb_pkg.sv
rtl/stream_fifo.sv
rtl/pixel_run_writer.sv
rtl/frame_store.sv
rtl/scan_prefetch.sv
rtl/raster_timing.sv
rtl/fb_display_top.sv
verification/fb_display_checker.sv
verification/fb_display_tb.sv

/* Makefile */
# Verilator build for the frame-buffer display testbench

VERILATOR  ?= verilator
TOP        ?= fb_display_tb
RTL_TOP    ?= fb_display_top
FILELIST   ?= filelist.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing
SOURCES    := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
